/* data/expand3_weights.hex */
// One line per tap: filter 7 word first, filter 0 word in the low 16 bits
20000000FE00020008000100E0002000
01000000FE000200F8000200E0002000
01000000FE00020008000300E0002000
01000000FE000200F8000400E0002000
01000000FE00020008000500E0002000
01000000FE000200F8000600E0002000
01000000FE00020008000700E0002000
01000000FE000200F8000800E0002000
01004000FE00020008000900E0002000
01004000FE000200F8000A00E0002000
01000000FE00020008000B00E0002000
01000000FE000200F8000C00E0002000
01000000FE00020008000D00E0002000
01000000FE000200F8000E00E0002000
01000000FE00020008000F00E0002000
01000000FE000200F8001000E0002000
01000000FE00020008001100E0002000
E0000000FE000200F8001200E0002000

/* data/expand3_bias.hex */
// One 32-bit bias per filter, filter 0 first, product scale
00000000
08000000
00400000
F8000000
02000000
01000000
00000000
FFC00000

/* build.f */
common/cnn_fmt_pkg.sv
common/layer_cfg_pkg.sv
source/ifm_streamer.sv
expand3_conv/expand3_coeff_rom.sv
expand3_conv/expand3_mac.sv
expand3_conv/expand3_conv.sv
source/ofm_writer.sv
source/fire_expand3_top.sv
bench/tb_fire_expand3.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the expand3 testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f build.f \
	--top-module tb_fire_expand3 -o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation run returned status $status"
	exit 1
fi

if grep -q "^Simulation completed successfully$" "$LOG"; then
	exit 0
fi
exit 1

/* bench/tb_fire_expand3.sv */
`timescale 1ns/1ps

module tb_fire_expand3;

	localparam int RESET_CYCLES = 10;
	localparam int RUN_CYCLES = layer_cfg_pkg::NUM_PIX * layer_cfg_pkg::TAPS;
	// Reset, load, two full memory reads and the run plus a wide margin
	localparam int TEST_CYCLES = RESET_CYCLES + 2 * layer_cfg_pkg::IFM_WORDS +
		2 * (layer_cfg_pkg::OFM_WORDS + 2) + RUN_CYCLES + 20;
	localparam int TIMEOUT_CYCLES = 3 * TEST_CYCLES;
	localparam int PW = cnn_fmt_pkg::PIX_W;

	logic clk = 1'b0;
	logic rst;
	logic load_en;
	layer_cfg_pkg::ifm_addr_t load_addr;
	cnn_fmt_pkg::pix_t load_data;
	logic start;
	logic ack;
	logic busy;
	logic finish;
	layer_cfg_pkg::ofm_addr_t rd_addr;
	cnn_fmt_pkg::pix_t rd_data;

	int ifm [layer_cfg_pkg::IFM_WORDS];                     // Loaded pixels, channel-major
	logic [layer_cfg_pkg::NUM_FILTERS*PW-1:0] weights [layer_cfg_pkg::TAPS];
	logic [31:0] biases [layer_cfg_pkg::NUM_FILTERS];
	int value_errors = 0;
	int protocol_errors = 0;
	int cycle = 0;
	int sample_count = 0;
	int last_sample = 0;
	logic ack_taken = 1'b0;
	logic busy_seen = 1'b0;
	logic busy_fell = 1'b0;
	logic finish_q = 1'b0;

	fire_expand3_top dut (
		.clk(clk),
		.rst(rst),
		.load_en(load_en),
		.load_addr(load_addr),
		.load_data(load_data),
		.start(start),
		.busy(busy),
		.finish(finish),
		.ack(ack),
		.rd_addr(rd_addr),
		.rd_data(rd_data)
	);

	always #10 clk = ~clk;

	// ##########################################################
	// Reference model of one output word
	// ##########################################################
	function automatic int model_out(int p, int f);
		longint sum;
		longint w;
		int r;
		int c;
		int t;
		sum = longint'($signed(biases[f]));
		for (int kr = 0; kr < layer_cfg_pkg::KERNEL_DIM; kr++) begin
			for (int kc = 0; kc < layer_cfg_pkg::KERNEL_DIM; kc++) begin
				for (int ch = 0; ch < layer_cfg_pkg::CHIN; ch++) begin
					r = p / layer_cfg_pkg::WOUT + kr - 1;
					c = p % layer_cfg_pkg::WOUT + kc - 1;
					t = (kr * layer_cfg_pkg::KERNEL_DIM + kc) * layer_cfg_pkg::CHIN + ch;
					if (r >= 0 && r < layer_cfg_pkg::WOUT &&
						c >= 0 && c < layer_cfg_pkg::WOUT) begin
						w = longint'($signed(weights[t][f*PW +: PW]));
						sum += w * longint'(ifm[(ch * layer_cfg_pkg::WOUT + r) *
							layer_cfg_pkg::WOUT + c]);
					end
				end
			end
		end
		if (sum < 0)
			return 0;                                        // ReLU
		sum = sum >>> cnn_fmt_pkg::FRAC_BITS;
		return (sum > cnn_fmt_pkg::OUT_MAX) ? cnn_fmt_pkg::OUT_MAX : int'(sum);
	endfunction

	task automatic check_value(string name, int expected, int actual);
		assert (expected == actual)
		else begin
			value_errors++;
			$display("** Error %s: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	task automatic note_protocol(string what);
		protocol_errors++;
		$display("Protocol problem at cycle %0d: %s", cycle, what);
	endtask

	task automatic load_ifm();
		for (int i = 0; i < layer_cfg_pkg::IFM_WORDS; i++) begin
			@(posedge clk);
			load_en <= 1'b1;
			load_addr <= layer_cfg_pkg::ifm_addr_t'(i);
			load_data <= cnn_fmt_pkg::pix_t'(ifm[i]);
		end
		@(posedge clk);
		load_en <= 1'b0;
	endtask

	// Data of address i shows two edges after it is driven
	task automatic read_ofm(input bit expect_zero);
		string name;
		int a;
		for (int i = 0; i < layer_cfg_pkg::OFM_WORDS + 2; i++) begin
			@(posedge clk);
			if (i >= 2) begin
				a = i - 2;
				name = expect_zero ? $sformatf("ofm[%0d] before start", a) :
					$sformatf("ofm[%0d] pixel %0d filter %0d", a, a / 8, a % 8);
				check_value(name, expect_zero ? 0 : model_out(a / 8, a % 8), int'(rd_data));
			end
			if (i < layer_cfg_pkg::OFM_WORDS)
				rd_addr <= layer_cfg_pkg::ofm_addr_t'(i);
		end
	endtask

	// ##########################################################
	// Protocol monitor and timeout
	// ##########################################################
	always @(posedge clk) begin
		cycle = cycle + 1;
		if (cycle >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
			$display("Simulation failed");
			$finish;
		end else if (rst) begin
			if (dut.sample) begin
				if (sample_count > 0)
					check_value("sample spacing", layer_cfg_pkg::TAPS, cycle - last_sample);
				sample_count <= sample_count + 1;
				last_sample <= cycle;
			end
			assert (!finish || sample_count == layer_cfg_pkg::NUM_PIX)
			else note_protocol("finish rose before the last sample");
			assert (!(ack_taken && finish)) else note_protocol("finish high after ack");
			assert (!(finish_q && !finish && !ack_taken))
			else note_protocol("finish fell before ack");
			assert (!(finish && busy)) else note_protocol("busy still high while finish is high");
			assert (!(busy_fell && busy)) else note_protocol("busy rose again after the run");
			if (ack)
				ack_taken <= 1'b1;
			if (busy)
				busy_seen <= 1'b1;
			if (busy_seen && !busy)
				busy_fell <= 1'b1;
			finish_q <= finish;
		end
	end

	// ##########################################################
	// Stimulus
	// ##########################################################
	initial begin
		void'($urandom(32'h796f));
		rst = 1'b0;
		load_en = 1'b0;
		load_addr = '0;
		load_data = '0;
		start = 1'b0;
		ack = 1'b0;
		rd_addr = '0;
		$readmemh("data/expand3_weights.hex", weights);
		$readmemh("data/expand3_bias.hex", biases);
		for (int i = 0; i < layer_cfg_pkg::IFM_WORDS; i++)
			ifm[i] = int'($urandom % 16385);                // 0 to 1.0 in Q1.14
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b1;
		load_ifm();
		@(posedge clk);
		assert (!busy && !finish) else note_protocol("busy or finish high before start");
		read_ofm(1'b1);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		while (sample_count < 4)
			@(posedge clk);
		start <= 1'b1;                                       // Must be ignored mid-run
		@(posedge clk);
		start <= 1'b0;
		while (!finish)
			@(posedge clk);
		read_ofm(1'b0);
		ack <= 1'b1;
		@(posedge clk);
		ack <= 1'b0;
		start <= 1'b1;                                       // No second run after the end
		@(posedge clk);
		start <= 1'b0;
		repeat (20) @(posedge clk);
		check_value("sample count", layer_cfg_pkg::NUM_PIX, sample_count);
		assert (!finish) else note_protocol("finish still high after ack");
		$display("Errors: value %0d, protocol %0d", value_errors, protocol_errors);
		if (value_errors + protocol_errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

/* source/fire_expand3_top.sv */
`timescale 1ns/1ps

module fire_expand3_top (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     load_en,
	input  layer_cfg_pkg::ifm_addr_t load_addr,
	input  cnn_fmt_pkg::pix_t        load_data,
	input  logic                     start,
	output logic                     busy,
	output logic                     finish,
	input  logic                     ack,
	input  layer_cfg_pkg::ofm_addr_t rd_addr,
	output cnn_fmt_pkg::pix_t        rd_data
);

	cnn_fmt_pkg::pix_t pix;
	logic pix_en;
	cnn_fmt_pkg::pix_t ofm [layer_cfg_pkg::NUM_FILTERS];
	logic sample;

	ifm_streamer u_streamer (
		.clk(clk),
		.rst(rst),
		.load_en(load_en),
		.load_addr(load_addr),
		.load_data(load_data),
		.start(start),
		.pix(pix),
		.pix_en(pix_en),
		.busy(busy)
	);

	expand3_conv u_conv (
		.clk(clk),
		.rst(rst),
		.pix(pix),
		.pix_en(pix_en),
		.ack(ack),
		.ofm(ofm),
		.sample(sample),
		.finish(finish)
	);

	ofm_writer u_writer (
		.clk(clk),
		.rst(rst),
		.ofm(ofm),
		.sample(sample),
		.rd_addr(rd_addr),
		.rd_data(rd_data)
	);

endmodule

/* source/ofm_writer.sv */
`timescale 1ns/1ps

module ofm_writer (
	input  logic                     clk,
	input  logic                     rst,
	input  cnn_fmt_pkg::pix_t        ofm [layer_cfg_pkg::NUM_FILTERS],
	input  logic                     sample,
	input  layer_cfg_pkg::ofm_addr_t rd_addr,
	output cnn_fmt_pkg::pix_t        rd_data
);

	cnn_fmt_pkg::pix_t cap [layer_cfg_pkg::NUM_FILTERS];
	cnn_fmt_pkg::pix_t mem [layer_cfg_pkg::OFM_WORDS];
	logic [layer_cfg_pkg::OFM_WORDS-1:0] written;  // Unwritten words read as zero
	logic wr_en;
	logic [$clog2(layer_cfg_pkg::NUM_FILTERS)-1:0] fcnt;
	layer_cfg_pkg::pix_idx_t pix_cnt;
	layer_cfg_pkg::ofm_addr_t wr_addr;

	assign wr_addr = layer_cfg_pkg::ofm_addr_t'(pix_cnt * layer_cfg_pkg::NUM_FILTERS + fcnt);

	always_ff @(posedge clk) begin
		if (sample)
			cap <= ofm;
	end

	// ##########################################################
	// Eight-word burst per output pixel
	// ##########################################################
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			wr_en <= 1'b0;
			fcnt <= '0;
			pix_cnt <= '0;
			written <= '0;
		end else if (sample) begin
			wr_en <= 1'b1;
			fcnt <= '0;
		end else if (wr_en) begin
			written[wr_addr] <= 1'b1;
			fcnt <= fcnt + 1'b1;
			if (fcnt == layer_cfg_pkg::NUM_FILTERS - 1) begin
				wr_en <= 1'b0;
				pix_cnt <= pix_cnt + 1'b1;  // Next pixel's slot
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr] <= cap[fcnt];
		rd_data <= written[rd_addr] ? mem[rd_addr] : '0;
	end

	a_no_sample_in_burst: assert property (@(posedge clk) disable iff (!rst)
		sample |-> !wr_en);

endmodule

/* expand3_conv/expand3_conv.sv */
`timescale 1ns/1ps

module expand3_conv (
	input  logic              clk,
	input  logic              rst,
	input  cnn_fmt_pkg::pix_t pix,
	input  logic              pix_en,
	input  logic              ack,
	output cnn_fmt_pkg::pix_t ofm [layer_cfg_pkg::NUM_FILTERS],
	output logic              sample,
	output logic              finish
);

	layer_cfg_pkg::tap_t tap;
	cnn_fmt_pkg::pix_t pix_d;
	logic pix_en_d, clr, last_d, acc_done;
	cnn_fmt_pkg::pix_t kernels [layer_cfg_pkg::NUM_FILTERS];
	cnn_fmt_pkg::bias_t biases [layer_cfg_pkg::NUM_FILTERS];
	cnn_fmt_pkg::acc_t acc [layer_cfg_pkg::NUM_FILTERS];
	logic signed [cnn_fmt_pkg::ACC_W:0] sum [layer_cfg_pkg::NUM_FILTERS];
	logic signed [cnn_fmt_pkg::ACC_W:0] shifted [layer_cfg_pkg::NUM_FILTERS];
	cnn_fmt_pkg::pix_t q [layer_cfg_pkg::NUM_FILTERS];
	layer_cfg_pkg::pix_idx_t pix_cnt;
	logic layer_done, ack_seen;

	expand3_coeff_rom u_rom (
		.clk(clk),
		.tap(tap),
		.kernels(kernels),
		.biases(biases)
	);

	// ##########################################################
	// Tap counter and alignment with the ROM latency
	// ##########################################################
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			tap <= '0;
			pix_en_d <= 1'b0;
			clr <= 1'b0;
			last_d <= 1'b0;
			acc_done <= 1'b0;
		end else begin
			pix_en_d <= pix_en;
			clr <= pix_en && (tap == 0);                                // First tap loads
			last_d <= pix_en && (tap == layer_cfg_pkg::TAPS - 1);
			acc_done <= last_d;                                         // Window sum ready
			if (pix_en)
				tap <= (tap == layer_cfg_pkg::TAPS - 1) ? '0 : tap + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		pix_d <= pix;
	end

	for (genvar f = 0; f < layer_cfg_pkg::NUM_FILTERS; f++) begin : g_lane
		expand3_mac u_mac (
			.clk(clk),
			.rst(rst),
			.clr(clr),
			.en(pix_en_d),
			.pix(pix_d),
			.ker(kernels[f]),
			.acc(acc[f])
		);
	end

	// Bias, ReLU, then back to Q1.14 with clipping
	always_comb begin
		for (int f = 0; f < layer_cfg_pkg::NUM_FILTERS; f++) begin
			sum[f] = (cnn_fmt_pkg::ACC_W + 1)'(acc[f]) + (cnn_fmt_pkg::ACC_W + 1)'(biases[f]);
			shifted[f] = sum[f] >>> cnn_fmt_pkg::FRAC_BITS;
			if (sum[f] < 0)
				q[f] = '0;
			else if (shifted[f] > cnn_fmt_pkg::OUT_MAX)
				q[f] = cnn_fmt_pkg::pix_t'(cnn_fmt_pkg::OUT_MAX);
			else
				q[f] = shifted[f][cnn_fmt_pkg::PIX_W-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (acc_done)
			ofm <= q;
	end

	// ##########################################################
	// Layer end and finish handshake
	// ##########################################################
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			sample <= 1'b0;
			pix_cnt <= '0;
			layer_done <= 1'b0;
			ack_seen <= 1'b0;
		end else begin
			sample <= acc_done && !layer_done;
			if (sample)
				pix_cnt <= pix_cnt + 1'b1;
			if (sample && pix_cnt == layer_cfg_pkg::NUM_PIX - 1)
				layer_done <= 1'b1;  // Last output pixel out
			if (ack)
				ack_seen <= 1'b1;    // Held until the next reset
		end
	end

	assign finish = layer_done && !ack_seen;

	a_no_window_after_end: assert property (@(posedge clk) disable iff (!rst)
		acc_done |-> !layer_done);
	a_clr_on_window_start: assert property (@(posedge clk) disable iff (!rst)
		clr |-> pix_en_d && (!$past(pix_en_d) || $past(last_d)));

endmodule

/* expand3_conv/expand3_mac.sv */
`timescale 1ns/1ps

module expand3_mac (
	input  logic              clk,
	input  logic              rst,
	input  logic              clr,
	input  logic              en,
	input  cnn_fmt_pkg::pix_t pix,
	input  cnn_fmt_pkg::pix_t ker,
	output cnn_fmt_pkg::acc_t acc
);

	cnn_fmt_pkg::prod_t prod;

	assign prod = pix * ker;  // Signed Q1.14 times Q1.14

	always_ff @(posedge clk or negedge rst) begin
		if (!rst)
			acc <= '0;
		else if (en) begin
			if (clr)
				acc <= cnn_fmt_pkg::acc_t'(prod);  // New window starts here
			else
				acc <= acc + prod;
		end
	end

endmodule

/* expand3_conv/expand3_coeff_rom.sv */
`timescale 1ns/1ps

module expand3_coeff_rom (
	input  logic                clk,
	input  layer_cfg_pkg::tap_t tap,
	output cnn_fmt_pkg::pix_t   kernels [layer_cfg_pkg::NUM_FILTERS],
	output cnn_fmt_pkg::bias_t  biases [layer_cfg_pkg::NUM_FILTERS]
);

	// One line per tap, filter 0 in the low word
	logic [layer_cfg_pkg::NUM_FILTERS*cnn_fmt_pkg::PIX_W-1:0] rom [layer_cfg_pkg::TAPS];
	logic [layer_cfg_pkg::NUM_FILTERS*cnn_fmt_pkg::PIX_W-1:0] row_q;
	cnn_fmt_pkg::bias_t bias_mem [layer_cfg_pkg::NUM_FILTERS];

	initial begin
		$readmemh("data/expand3_weights.hex", rom);
		$readmemh("data/expand3_bias.hex", bias_mem);
	end

	always_ff @(posedge clk) begin
		row_q <= rom[tap];  // One cycle read latency
	end

	always_comb begin
		for (int f = 0; f < layer_cfg_pkg::NUM_FILTERS; f++) begin
			kernels[f] = row_q[f*cnn_fmt_pkg::PIX_W +: cnn_fmt_pkg::PIX_W];
			biases[f] = bias_mem[f];
		end
	end

endmodule

/* source/ifm_streamer.sv */
`timescale 1ns/1ps

module ifm_streamer (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     load_en,
	input  layer_cfg_pkg::ifm_addr_t load_addr,
	input  cnn_fmt_pkg::pix_t        load_data,
	input  logic                     start,
	output cnn_fmt_pkg::pix_t        pix,
	output logic                     pix_en,
	output logic                     busy
);

	cnn_fmt_pkg::pix_t mem [layer_cfg_pkg::IFM_WORDS];

	layer_cfg_pkg::state_t state;
	layer_cfg_pkg::pix_idx_t pix_idx;                          // Output pixel
	logic [$clog2(layer_cfg_pkg::KERNEL_DIM)-1:0] kr, kc;     // Kernel position
	logic [$clog2(layer_cfg_pkg::CHIN)-1:0] ch;                // Innermost

	logic [1:0] out_r, out_c;
	logic signed [3:0] in_r, in_c;
	logic pad;
	layer_cfg_pkg::ifm_addr_t rd_addr;

	// ##########################################################
	// Kernel-order address with zero padding
	// ##########################################################
	always_comb begin
		out_r = 2'(pix_idx / layer_cfg_pkg::WOUT);
		out_c = 2'(pix_idx % layer_cfg_pkg::WOUT);
		in_r = $signed({2'b00, out_r}) + $signed({2'b00, kr}) - 4'sd1;
		in_c = $signed({2'b00, out_c}) + $signed({2'b00, kc}) - 4'sd1;
		pad = (in_r < 0) || (in_r >= layer_cfg_pkg::WOUT) ||
			(in_c < 0) || (in_c >= layer_cfg_pkg::WOUT);
		rd_addr = layer_cfg_pkg::ifm_addr_t'(ch * layer_cfg_pkg::WOUT * layer_cfg_pkg::WOUT +
			in_r[1:0] * layer_cfg_pkg::WOUT + in_c[1:0]);
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= layer_cfg_pkg::idle;
			pix_idx <= '0;
			kr <= '0;
			kc <= '0;
			ch <= '0;
		end else begin
			case (state)
				layer_cfg_pkg::idle: if (start) state <= layer_cfg_pkg::stream;
				layer_cfg_pkg::stream: begin
					if (ch == layer_cfg_pkg::CHIN - 1) begin
						ch <= '0;
						if (kc == layer_cfg_pkg::KERNEL_DIM - 1) begin
							kc <= '0;
							if (kr == layer_cfg_pkg::KERNEL_DIM - 1) begin
								kr <= '0;
								pix_idx <= pix_idx + 1'b1;
								if (pix_idx == layer_cfg_pkg::NUM_PIX - 1)
									state <= layer_cfg_pkg::done;  // Last tap issued
							end else
								kr <= kr + 1'b1;
						end else
							kc <= kc + 1'b1;
					end else
						ch <= ch + 1'b1;
				end
				default: state <= layer_cfg_pkg::done;  // One run per reset
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst)
			pix_en <= 1'b0;
		else
			pix_en <= (state == layer_cfg_pkg::stream);
	end

	// Load port and registered tap read
	always_ff @(posedge clk) begin
		if (load_en)
			mem[load_addr] <= load_data;
		if (state == layer_cfg_pkg::stream)
			pix <= pad ? '0 : mem[rd_addr];  // Border taps skip the read
	end

	assign busy = (state == layer_cfg_pkg::stream) || pix_en;

	a_pix_en_until_end: assert property (@(posedge clk) disable iff (!rst)
		$fell(pix_en) |-> state == layer_cfg_pkg::done && pix_idx == '0);

endmodule

/* common/layer_cfg_pkg.sv */
package layer_cfg_pkg;

	localparam int CHIN        = 2;                            // Input channels
	localparam int KERNEL_DIM  = 3;
	localparam int WOUT        = 4;                            // Same as input width
	localparam int NUM_FILTERS = 8;
	localparam int TAPS        = KERNEL_DIM * KERNEL_DIM * CHIN;
	localparam int NUM_PIX     = WOUT * WOUT;
	localparam int IFM_WORDS   = CHIN * WOUT * WOUT;
	localparam int OFM_WORDS   = NUM_PIX * NUM_FILTERS;

	typedef logic [$clog2(TAPS)-1:0]      tap_t;
	typedef logic [$clog2(NUM_PIX)-1:0]   pix_idx_t;
	typedef logic [$clog2(IFM_WORDS)-1:0] ifm_addr_t;
	typedef logic [$clog2(OFM_WORDS)-1:0] ofm_addr_t;

	typedef enum logic [1:0] {idle, stream, done} state_t;  // Streamer FSM

endpackage

/* common/cnn_fmt_pkg.sv */
package cnn_fmt_pkg;

	// ##########################################################
	// Fixed-point word widths
	// ##########################################################
	localparam int PIX_W  = 16;            // Pixel and weight word
	localparam int PROD_W = 2 * PIX_W;     // Full product
	localparam int ACC_W  = PROD_W + 1;    // One guard bit for the sum of taps

	typedef logic signed [PIX_W-1:0]  pix_t;   // Q1.14 pixel, weight or result
	typedef logic signed [PROD_W-1:0] prod_t;  // Q2.28 product
	typedef logic signed [ACC_W-1:0]  acc_t;   // Running sum of products
	typedef logic signed [PROD_W-1:0] bias_t;  // Bias in product scale

	// ##########################################################
	// Requantization
	// ##########################################################
	localparam int FRAC_BITS = 14;         // Product scale back to pixel scale
	localparam int OUT_MAX   = 32767;      // Clip level after ReLU

endpackage
